// ==== src/dnn_cfg.svh ====
`ifndef DNN_CFG_SVH
`define DNN_CFG_SVH

// word and block geometry
`define DNN_WORD_W 64
`define DNN_BLK_WORDS 8
`define DNN_WORD_IDX_W 3

// index widths
`define DNN_LAYER_W 2
`define DNN_NEURON_W 3
`define DNN_WIDX_W 4
`define DNN_BLK_AW 4
`define DNN_STORE_AW 7

// preload address is block address above word index
`define DNN_ROM_AW (`DNN_BLK_AW + `DNN_WORD_IDX_W)

// layer shape, layer 0 first
`define DNN_NUM_LAYERS 4
`define DNN_LAYER_NEURONS '{3, 4, 2, 1}
`define DNN_LAYER_WEIGHTS '{10, 6, 9, 4}
`define DNN_LAYER_BASE '{0, 30, 54, 72}

`define DNN_STORE_DEPTH 76
// each neuron takes ceil(weights / 8) blocks
`define DNN_TOTAL_BLOCKS 15
`define DNN_MEM_LAT 3

`endif

// ==== src/dnn_pkg.sv ====
`include "dnn_cfg.svh"

package dnn_pkg;

  // one weight word
  typedef logic [`DNN_WORD_W-1:0] weight_t;

  // indices into the layer / neuron / weight space
  typedef logic [`DNN_LAYER_W-1:0] layer_t;
  typedef logic [`DNN_NEURON_W-1:0] neuron_t;
  typedef logic [`DNN_WIDX_W-1:0] widx_t;

  // block memory and weight store addresses
  typedef logic [`DNN_BLK_AW-1:0] blk_addr_t;
  typedef logic [`DNN_STORE_AW-1:0] store_addr_t;

  typedef enum logic [2:0] {
    IDLE,
    GET_MEM,     // waiting on mem_ready
    LD_WEIGHTS,  // one write per cycle
    NEW_NEURON,
    DONE
  } ld_state_t;

endpackage

// ==== src/weight_wr_if.sv ====
`timescale 1ns/100ps

interface weight_wr_if;

  logic              write_weight;
  dnn_pkg::weight_t  weight_bus;
  dnn_pkg::layer_t   layer_sel;
  dnn_pkg::neuron_t  neuron_sel;
  dnn_pkg::widx_t    weight_sel;  // index within the neuron

  modport source (
    output write_weight,
    output weight_bus,
    output layer_sel,
    output neuron_sel,
    output weight_sel
  );

  modport sink (
    input write_weight,
    input weight_bus,
    input layer_sel,
    input neuron_sel,
    input weight_sel
  );

endinterface

// ==== src/weight_block_fetch.sv ====
`timescale 1ns/100ps
`include "dnn_cfg.svh"

module weight_block_fetch (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  rom_wr,
  input  logic [`DNN_ROM_AW-1:0]                rom_addr,
  input  dnn_pkg::weight_t                      rom_data,
  input  logic                                  req_mem,
  output logic                                  mem_ready,
  output dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] mem_data
);

  localparam int LAT = `DNN_MEM_LAT;
  localparam int BLOCKS = `DNN_TOTAL_BLOCKS;

  // staging ram with one packed block per entry
  dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] ram [BLOCKS];

  // read-out delay line
  dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] dly_data [LAT];
  logic [LAT-1:0] dly_vld;

  dnn_pkg::blk_addr_t blk_ptr;
  dnn_pkg::blk_addr_t wr_blk;
  logic [`DNN_WORD_IDX_W-1:0] wr_word;

  assign wr_blk = rom_addr[`DNN_ROM_AW-1:`DNN_WORD_IDX_W];
  assign wr_word = rom_addr[`DNN_WORD_IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rom_wr)
      ram[wr_blk][wr_word] <= rom_data;
  end

  // next block to hand out
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      blk_ptr <= '0;
    end else if (req_mem) begin
      if (blk_ptr == dnn_pkg::blk_addr_t'(BLOCKS - 1))
        blk_ptr <= '0;  // wrap after last block
      else
        blk_ptr <= blk_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      dly_vld <= '0;
    end else begin
      dly_vld[0] <= req_mem;
      for (int i = 1; i < LAT; i++)
        dly_vld[i] <= dly_vld[i-1];
    end
  end

  // snapshot on request then shift down the line
  always_ff @(posedge clk) begin
    if (req_mem)
      dly_data[0] <= ram[blk_ptr];
    for (int i = 1; i < LAT; i++)
      dly_data[i] <= dly_data[i-1];
  end

  assign mem_ready = dly_vld[LAT-1];
  assign mem_data = dly_data[LAT-1];

  // loader must wait for mem_ready before asking again
  a_one_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_mem |-> dly_vld == '0
  ) else $error("req_mem issued while a block fetch is still pending");

endmodule

// ==== src/dnn_weight_ld.sv ====
`timescale 1ns/100ps
`include "dnn_cfg.svh"

module dnn_weight_ld (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic                                  mem_ready,
  input  dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] mem_data,
  output logic                                  req_mem,
  output logic                                  busy,
  output logic                                  load_done,
  weight_wr_if.source                           wr
);

  localparam int NEURONS [`DNN_NUM_LAYERS] = `DNN_LAYER_NEURONS;
  localparam int WEIGHTS [`DNN_NUM_LAYERS] = `DNN_LAYER_WEIGHTS;

  dnn_pkg::ld_state_t state, nxt_state;

  logic [`DNN_WORD_IDX_W-1:0] word_cnt;
  dnn_pkg::widx_t weight_cnt;
  dnn_pkg::neuron_t neuron_cnt;
  dnn_pkg::layer_t layer_cnt;
  dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] blk_reg;

  logic last_weight, last_neuron, last_layer;
  logic write_weight, store_blk;
  logic clr_all, next_neuron, next_layer;

  // limits from the shape table for the current layer
  assign last_weight = weight_cnt == dnn_pkg::widx_t'(WEIGHTS[layer_cnt] - 1);
  assign last_neuron = neuron_cnt == dnn_pkg::neuron_t'(NEURONS[layer_cnt] - 1);
  assign last_layer = layer_cnt == dnn_pkg::layer_t'(`DNN_NUM_LAYERS - 1);

  // word within the latched block
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      word_cnt <= '0;
    else if (store_blk)
      word_cnt <= '0;
    else if (write_weight)
      word_cnt <= word_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      weight_cnt <= '0;
    else if (clr_all || next_neuron || next_layer)
      weight_cnt <= '0;
    else if (write_weight)
      weight_cnt <= weight_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      neuron_cnt <= '0;
    else if (clr_all || next_layer)
      neuron_cnt <= '0;
    else if (next_neuron)
      neuron_cnt <= neuron_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      layer_cnt <= '0;
    else if (clr_all)
      layer_cnt <= '0;
    else if (next_layer)
      layer_cnt <= layer_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (store_blk)
      blk_reg <= mem_data;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= dnn_pkg::IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    req_mem = 1'b0;
    write_weight = 1'b0;
    store_blk = 1'b0;
    clr_all = 1'b0;
    next_neuron = 1'b0;
    next_layer = 1'b0;
    case (state)
      dnn_pkg::IDLE: begin
        if (start) begin
          req_mem = 1'b1;
          clr_all = 1'b1;
          nxt_state = dnn_pkg::GET_MEM;
        end
      end
      dnn_pkg::GET_MEM: begin
        if (mem_ready) begin
          store_blk = 1'b1;
          nxt_state = dnn_pkg::LD_WEIGHTS;
        end
      end
      dnn_pkg::LD_WEIGHTS: begin
        write_weight = 1'b1;
        if (last_weight) begin
          nxt_state = dnn_pkg::NEW_NEURON;  // rest of block dropped
        end else if (word_cnt == '1) begin
          req_mem = 1'b1;  // neuron spills into next block
          nxt_state = dnn_pkg::GET_MEM;
        end
      end
      dnn_pkg::NEW_NEURON: begin
        if (last_neuron && last_layer) begin
          nxt_state = dnn_pkg::DONE;
        end else begin
          req_mem = 1'b1;
          next_neuron = !last_neuron;
          next_layer = last_neuron;
          nxt_state = dnn_pkg::GET_MEM;
        end
      end
      dnn_pkg::DONE: nxt_state = dnn_pkg::IDLE;
      default: nxt_state = dnn_pkg::IDLE;
    endcase
  end

  assign busy = state != dnn_pkg::IDLE;
  assign load_done = state == dnn_pkg::DONE;

  assign wr.write_weight = write_weight;
  assign wr.weight_bus = blk_reg[word_cnt];
  assign wr.layer_sel = layer_cnt;
  assign wr.neuron_sel = neuron_cnt;
  assign wr.weight_sel = weight_cnt;

  // writes stay inside the current neuron and layer
  a_wr_in_shape: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr.write_weight |-> int'(weight_cnt) < WEIGHTS[layer_cnt]
                        && int'(neuron_cnt) < NEURONS[layer_cnt]
  ) else $error("weight write outside the layer shape");

  // fetch reply only lands while we wait for it
  a_ready_in_get: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_ready |-> state == dnn_pkg::GET_MEM
  ) else $error("mem_ready arrived outside GET_MEM");

endmodule

// ==== src/neuron_weight_store.sv ====
`timescale 1ns/100ps
`include "dnn_cfg.svh"

module neuron_weight_store (
  input  logic                 clk,
  input  logic                 rst_n,
  weight_wr_if.sink            wr,
  input  dnn_pkg::store_addr_t rd_addr,
  output dnn_pkg::weight_t     rd_data
);

  localparam int BASE [`DNN_NUM_LAYERS] = `DNN_LAYER_BASE;
  localparam int WEIGHTS [`DNN_NUM_LAYERS] = `DNN_LAYER_WEIGHTS;
  localparam int DEPTH = `DNN_STORE_DEPTH;

  dnn_pkg::weight_t mem [DEPTH];

  int wr_addr_full;
  dnn_pkg::store_addr_t wr_addr;

  // base of layer + neuron * weights per neuron + weight index
  always_comb begin
    wr_addr_full = BASE[wr.layer_sel]
                 + int'(wr.neuron_sel) * WEIGHTS[wr.layer_sel]
                 + int'(wr.weight_sel);
  end

  assign wr_addr = dnn_pkg::store_addr_t'(wr_addr_full);

  always_ff @(posedge clk) begin
    if (wr.write_weight)
      mem[wr_addr] <= wr.weight_bus;
  end

  // registered readback
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // selects coming from the loader must land inside the store
  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr.write_weight |-> wr_addr_full < DEPTH
  ) else $error("weight write address %0d beyond store depth", wr_addr_full);

endmodule

// ==== src/dnn_weight_sys.sv ====
`timescale 1ns/100ps
`include "dnn_cfg.svh"

module dnn_weight_sys (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rom_wr,
  input  logic [`DNN_ROM_AW-1:0] rom_addr,
  input  dnn_pkg::weight_t      rom_data,
  input  logic                  start,
  input  dnn_pkg::store_addr_t  rd_addr,
  output logic                  load_done,
  output logic                  busy,
  output dnn_pkg::weight_t      rd_data
);

  logic req_mem;
  logic mem_ready;
  dnn_pkg::weight_t [`DNN_BLK_WORDS-1:0] mem_data;

  weight_wr_if wr_bus ();

  weight_block_fetch fetch0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .rom_wr    (rom_wr),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data),
    .req_mem   (req_mem),
    .mem_ready (mem_ready),
    .mem_data  (mem_data)
  );

  dnn_weight_ld loader0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .mem_ready (mem_ready),
    .mem_data  (mem_data),
    .req_mem   (req_mem),
    .busy      (busy),
    .load_done (load_done),
    .wr        (wr_bus.source)
  );

  neuron_weight_store store0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr_bus.sink),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;  // 100 ns clock
  localparam int RST_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // power-on reset, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb/dnn_weight_sys_tb.sv ====
`timescale 1ns/100ps
`include "dnn_cfg.svh"

module dnn_weight_sys_tb;

  localparam int NEURONS [`DNN_NUM_LAYERS] = `DNN_LAYER_NEURONS;
  localparam int WEIGHTS [`DNN_NUM_LAYERS] = `DNN_LAYER_WEIGHTS;
  localparam int ROM_WORDS = `DNN_TOTAL_BLOCKS * `DNN_BLK_WORDS;
  localparam int DEPTH = `DNN_STORE_DEPTH;

  logic clk, por_n, soft_rst_n, rst_n;
  logic rom_wr;
  logic [`DNN_ROM_AW-1:0] rom_addr;
  dnn_pkg::weight_t rom_data;
  logic start;
  dnn_pkg::store_addr_t rd_addr;
  logic load_done, busy;
  dnn_pkg::weight_t rd_data;

  dnn_pkg::weight_t rom_copy [ROM_WORDS];  // what the tb preloaded
  dnn_pkg::weight_t exp_w;
  int seed;
  int err_cnt, done_cnt, tests_run, tests_bad, load_limit;
  int e0, d0;
  logic cmp_en;
  int cmp_addr;

  clk_gen clk_gen0 (.clk(clk), .rst_n(por_n));

  assign rst_n = por_n & soft_rst_n;  // soft reset for the mid-load case

  dnn_weight_sys dut0 (
    .clk(clk), .rst_n(rst_n), .rom_wr(rom_wr), .rom_addr(rom_addr), .rom_data(rom_data),
    .start(start), .rd_addr(rd_addr), .load_done(load_done), .busy(busy), .rd_data(rd_data)
  );

  // cycles of one full load with fetch wait, latch, writes and neuron advance
  function automatic int load_len();
    int n, nb;
    n = 1;  // done cycle
    for (int l = 0; l < `DNN_NUM_LAYERS; l++) begin
      nb = (WEIGHTS[l] + `DNN_BLK_WORDS - 1) / `DNN_BLK_WORDS;
      n += NEURONS[l] * (nb * (`DNN_MEM_LAT + 1) + WEIGHTS[l] + 1);
    end
    return n;
  endfunction

  // maps a flat address back to its block and word, each neuron on a fresh block
  function automatic dnn_pkg::weight_t ref_weight(input int addr);
    int base, blk, nb, off, nrn, widx, word;
    bit found;
    base = 0;
    blk = 0;
    word = 0;
    found = 1'b0;
    for (int l = 0; l < `DNN_NUM_LAYERS; l++) begin
      nb = (WEIGHTS[l] + `DNN_BLK_WORDS - 1) / `DNN_BLK_WORDS;
      if (!found && addr < base + NEURONS[l] * WEIGHTS[l]) begin
        off = addr - base;
        nrn = off / WEIGHTS[l];
        widx = off % WEIGHTS[l];
        blk += nrn * nb + widx / `DNN_BLK_WORDS;
        word = widx % `DNN_BLK_WORDS;
        found = 1'b1;
      end else if (!found) begin
        base += NEURONS[l] * WEIGHTS[l];
        blk += NEURONS[l] * nb;
      end
    end
    return rom_copy[blk * `DNN_BLK_WORDS + word];
  endfunction

  task automatic preload();
    dnn_pkg::weight_t w;
    for (int i = 0; i < ROM_WORDS; i++) begin
      w = {$random(seed), $random(seed)};
      rom_copy[i] = w;
      @(posedge clk);
      rom_wr <= 1'b1;
      rom_addr <= i[`DNN_ROM_AW-1:0];
      rom_data <= w;
    end
    @(posedge clk);
    rom_wr <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    bit got_done;
    int n;
    got_done = 1'b0;
    n = 0;
    while (!got_done && n < load_limit) begin
      @(negedge clk);
      n++;
      assert (busy) else begin
        $display("ERR %0t: busy low before load_done", $time);
        err_cnt++;
      end
      if (load_done)
        got_done = 1'b1;
    end
    if (!got_done) begin
      $display("load_done did not arrive within %0d cycles of start", load_limit);
      err_cnt++;
    end
  endtask

  // compare lags one cycle behind rd_addr
  task automatic readback();
    for (int a = 0; a <= DEPTH; a++) begin
      @(posedge clk);
      if (a < DEPTH)
        rd_addr <= dnn_pkg::store_addr_t'(a);
      cmp_en <= (a > 0);
      cmp_addr <= a - 1;
    end
    @(posedge clk);
    cmp_en <= 1'b0;
  endtask

  task automatic settle_idle(input int d_before);
    repeat (6) @(negedge clk);
    assert (!busy) else begin
      $display("ERR %0t: busy still high after load_done", $time);
      err_cnt++;
    end
    assert (done_cnt - d_before == 1) else begin
      $display("ERR %0t: load_done seen %0d times, expected once", $time, done_cnt - d_before);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int e_before);
    int n;
    n = err_cnt - e_before;
    tests_run++;
    if (n != 0)
      tests_bad++;
    $display("test %0d %s: %s (%0d errors)", num, name, (n == 0) ? "ok" : "FAIL", n);
  endtask

  always @(negedge clk) begin
    if (load_done)
      done_cnt++;
  end

  always @(negedge clk) begin
    if (cmp_en) begin
      exp_w = ref_weight(cmp_addr);
      assert (rd_data === exp_w) else begin
        $display("ERR %0t: addr %0d read %h expected %h", $time, cmp_addr, rd_data, exp_w);
        err_cnt++;
      end
    end
  end

  // whole-run limit covers six loads plus preloads and readbacks
  initial begin
    int limit;
    limit = 6 * (2 * load_len() + 20) + 4 * (ROM_WORDS + 2) + 5 * (DEPTH + 2) + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rom_wr = 1'b0;
    rom_addr = '0;
    rom_data = '0;
    start = 1'b0;
    rd_addr = '0;
    soft_rst_n = 1'b1;
    cmp_en = 1'b0;
    cmp_addr = 0;
    seed = 71;
    err_cnt = 0;
    done_cnt = 0;
    tests_run = 0;
    tests_bad = 0;
    load_limit = 2 * load_len() + 20;
    @(posedge por_n);
    @(posedge clk);

    e0 = err_cnt;
    preload();
    pulse_start();
    wait_done();
    readback();
    report_test(1, "full load and readback", e0);

    e0 = err_cnt;  // pointer has wrapped back to block 0
    d0 = done_cnt;
    pulse_start();
    wait_done();
    settle_idle(d0);
    report_test(2, "load_done once, busy until done", e0);

    e0 = err_cnt;
    d0 = done_cnt;
    pulse_start();
    repeat (4) @(posedge clk);
    start <= 1'b1;  // must be ignored
    @(posedge clk);
    start <= 1'b0;
    wait_done();
    settle_idle(d0);
    readback();
    report_test(3, "start while busy ignored", e0);

    e0 = err_cnt;
    preload();
    pulse_start();
    wait_done();
    readback();
    report_test(4, "reload with new contents", e0);

    e0 = err_cnt;
    preload();
    pulse_start();
    repeat (20) @(posedge clk);
    soft_rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    soft_rst_n <= 1'b1;
    @(negedge clk);
    assert (!busy) else begin
      $display("ERR %0t: busy high after reset", $time);
      err_cnt++;
    end
    pulse_start();
    wait_done();
    readback();
    report_test(5, "reset mid-load then full load", e0);

    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+src
src/dnn_pkg.sv
src/weight_wr_if.sv
src/weight_block_fetch.sv
src/dnn_weight_ld.sv
src/neuron_weight_store.sv
src/dnn_weight_sys.sv
tb/clk_gen.sv
tb/dnn_weight_sys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the weight loader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module dnn_weight_sys_tb \
  -o dnn_weight_sim

out="$(./obj_dir/dnn_weight_sim)"
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi
